// ==== design/core_state_regs.sv ====
`timescale 1ns/1ns

module core_state_regs #(
    parameter int ADDR_WIDTH = mem_addr_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = mem_addr_pkg::DATA_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_addr_pkg::mem_cmd_t     cmd,
    input  mem_addr_pkg::addr_result_t res,
    output logic [ADDR_WIDTH-1:0]      pc,
    output logic [DATA_WIDTH-1:0]      cur_sp
);

    logic [DATA_WIDTH-1:0] kernel_sp;
    logic [DATA_WIDTH-1:0] user_sp;

    // Pointer of the commanded mode
    assign cur_sp = cmd.kernel ? kernel_sp : user_sp;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (cmd.valid) begin
            pc <= pc + ADDR_WIDTH'(1);           // One word per command
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_sp <= mem_addr_pkg::SP_EMPTY_MARK;
            user_sp   <= mem_addr_pkg::SP_EMPTY_MARK;
        end else if (cmd.valid) begin
            if (cmd.kernel) begin
                kernel_sp <= res.next_sp;
            end else begin
                user_sp <= res.next_sp;          // Other mode left untouched
            end
        end
    end

endmodule

// ==== design/data_memory.sv ====
`timescale 1ns/1ns

module data_memory #(
    parameter int DEPTH      = 8192,
    parameter int ADDR_WIDTH = mem_addr_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = mem_addr_pkg::DATA_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_addr_pkg::addr_result_t res,
    input  logic [DATA_WIDTH-1:0]      wdata,
    output logic [DATA_WIDTH-1:0]      rd_data,
    output logic                       rd_valid
);

    localparam int IDX_WIDTH = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [ADDR_WIDTH-1:0] word_addr;
    logic [IDX_WIDTH-1:0]  idx;

    assign word_addr = res.mem_addr;
    assign idx       = word_addr[IDX_WIDTH-1:0];   // Map covers the whole array

    always_ff @(posedge clk) begin
        if (res.mem_we) begin
            mem[idx] <= wdata;
        end
    end

    // Registered read port, data one cycle after the command
    always_ff @(posedge clk) begin
        if (res.mem_re) begin
            rd_data <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= res.mem_re;              // Pulse per read issued
        end
    end

endmodule

// ==== design/mem_addr_pkg.sv ====
package mem_addr_pkg;

    localparam int ADDR_WIDTH = 16;              // Word address bits
    localparam int DATA_WIDTH = 32;              // Data word and SP bits

    // Memory map in words
    localparam int CODE_AREA_SIZE    = 4096;
    localparam int KERNEL_STACK_SIZE = 2048;
    localparam int USER_STACK_SIZE   = 2048;

    localparam logic [DATA_WIDTH-1:0] SP_EMPTY_MARK = '1;  // Empty stack marker

    typedef enum logic [1:0] {
        OP_ACCESS = 2'd0,                        // Plain load/store
        OP_PUSH   = 2'd1,
        OP_POP    = 2'd2
    } stack_op_t;

    typedef enum logic [2:0] {
        SP_HOLD  = 3'd0,
        SP_INC   = 3'd1,
        SP_DEC   = 3'd2,
        SP_EMPTY = 3'd3,                         // Load the empty marker
        SP_FIRST = 3'd4                          // Load the highest slot
    } sp_step_t;

    typedef struct packed {
        logic                  valid;
        stack_op_t             op;
        logic                  kernel;           // Kernel stack selected
        logic                  write;            // Only for OP_ACCESS
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] mem_addr;
        logic                  mem_we;
        logic                  mem_re;
        logic [DATA_WIDTH-1:0] next_sp;
        logic                  fault;            // Overflow or underflow
    } addr_result_t;

endpackage

// ==== design/mem_addr_top.sv ====
`timescale 1ns/1ns

module mem_addr_top #(
    parameter int ADDR_WIDTH        = mem_addr_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH        = mem_addr_pkg::DATA_WIDTH,
    parameter int CODE_AREA_SIZE    = mem_addr_pkg::CODE_AREA_SIZE,
    parameter int KERNEL_STACK_SIZE = mem_addr_pkg::KERNEL_STACK_SIZE,
    parameter int USER_STACK_SIZE   = mem_addr_pkg::USER_STACK_SIZE
) (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_addr_pkg::mem_cmd_t cmd,
    output logic [ADDR_WIDTH-1:0]  instr_addr,
    output logic [ADDR_WIDTH-1:0]  pc,
    output logic [DATA_WIDTH-1:0]  sp,
    output logic                   rd_valid,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic                   stack_fault
);

    // Data memory spans code area and both stacks
    localparam int MEM_DEPTH = CODE_AREA_SIZE + KERNEL_STACK_SIZE + USER_STACK_SIZE;

    mem_addr_pkg::addr_result_t res;
    logic [DATA_WIDTH-1:0]      cur_sp;

    assign sp          = cur_sp;
    assign stack_fault = res.fault;

    core_state_regs #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_state (
        .clk   (clk),
        .rst   (rst),
        .cmd   (cmd),
        .res   (res),
        .pc    (pc),
        .cur_sp(cur_sp)
    );

    memory_address_handler #(
        .ADDR_WIDTH       (ADDR_WIDTH),
        .DATA_WIDTH       (DATA_WIDTH),
        .CODE_AREA_SIZE   (CODE_AREA_SIZE),
        .KERNEL_STACK_SIZE(KERNEL_STACK_SIZE),
        .USER_STACK_SIZE  (USER_STACK_SIZE)
    ) u_handler (
        .rst       (rst),
        .cmd       (cmd),
        .pc        (pc),
        .cur_sp    (cur_sp),
        .instr_addr(instr_addr),
        .res       (res)
    );

    data_memory #(
        .DEPTH     (MEM_DEPTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_dmem (
        .clk     (clk),
        .rst     (rst),
        .res     (res),
        .wdata   (cmd.wdata),
        .rd_data (rd_data),
        .rd_valid(rd_valid)
    );

endmodule

// ==== design/memory_address_handler.sv ====
`timescale 1ns/1ns

module memory_address_handler #(
    parameter int ADDR_WIDTH        = mem_addr_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH        = mem_addr_pkg::DATA_WIDTH,
    parameter int CODE_AREA_SIZE    = mem_addr_pkg::CODE_AREA_SIZE,
    parameter int KERNEL_STACK_SIZE = mem_addr_pkg::KERNEL_STACK_SIZE,
    parameter int USER_STACK_SIZE   = mem_addr_pkg::USER_STACK_SIZE
) (
    input  logic                       rst,
    input  mem_addr_pkg::mem_cmd_t     cmd,
    input  logic [ADDR_WIDTH-1:0]      pc,
    input  logic [DATA_WIDTH-1:0]      cur_sp,
    output logic [ADDR_WIDTH-1:0]      instr_addr,
    output mem_addr_pkg::addr_result_t res
);

    // Stack bounds, both stacks sit right above the code area
    localparam int KSTACK_LOW  = CODE_AREA_SIZE;
    localparam int KSTACK_HIGH = CODE_AREA_SIZE + KERNEL_STACK_SIZE - 1;
    localparam int USTACK_LOW  = CODE_AREA_SIZE + KERNEL_STACK_SIZE;
    localparam int USTACK_HIGH = USTACK_LOW + USER_STACK_SIZE - 1;

    logic [DATA_WIDTH-1:0]  stack_low;
    logic [DATA_WIDTH-1:0]  stack_high;
    logic [DATA_WIDTH-1:0]  next_sp;
    logic                   sp_empty;
    mem_addr_pkg::sp_step_t step;
    logic [ADDR_WIDTH-1:0]  addr;
    logic                   access;
    logic                   is_write;
    logic                   fault;

    assign instr_addr = rst ? '0 : pc;       // Fetch address held at zero in reset

    assign stack_low  = cmd.kernel ? DATA_WIDTH'(KSTACK_LOW) : DATA_WIDTH'(USTACK_LOW);
    assign stack_high = cmd.kernel ? DATA_WIDTH'(KSTACK_HIGH) : DATA_WIDTH'(USTACK_HIGH);
    assign sp_empty   = (cur_sp == mem_addr_pkg::SP_EMPTY_MARK);

    sp_incrementor #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_sp_incr (
        .step (step),
        .cur  (cur_sp),
        .first(stack_high),
        .next (next_sp)
    );

    always_comb begin
        step     = mem_addr_pkg::SP_HOLD;
        addr     = cmd.addr;
        access   = 1'b0;
        is_write = 1'b0;
        fault    = 1'b0;
        case (cmd.op)
            mem_addr_pkg::OP_PUSH: begin
                addr = next_sp[ADDR_WIDTH-1:0];  // Write lands at the new SP
                if (sp_empty) begin
                    step     = mem_addr_pkg::SP_FIRST;
                    access   = 1'b1;
                    is_write = 1'b1;
                end else if (cur_sp > stack_low) begin
                    step     = mem_addr_pkg::SP_DEC;
                    access   = 1'b1;
                    is_write = 1'b1;
                end else begin
                    fault = 1'b1;                // Overflow
                end
            end
            mem_addr_pkg::OP_POP: begin
                addr = cur_sp[ADDR_WIDTH-1:0];   // Read the current top
                if (sp_empty) begin
                    fault = 1'b1;                // Underflow
                end else begin
                    access = 1'b1;
                    step   = (cur_sp < stack_high) ? mem_addr_pkg::SP_INC
                                                   : mem_addr_pkg::SP_EMPTY;
                end
            end
            default: begin
                access   = 1'b1;
                is_write = cmd.write;
            end
        endcase
    end

    always_comb begin
        res.mem_addr = addr;
        res.mem_we   = cmd.valid & access & is_write;
        res.mem_re   = cmd.valid & access & ~is_write;
        res.next_sp  = next_sp;
        res.fault    = cmd.valid & fault;
    end

endmodule

// ==== design/sp_incrementor.sv ====
`timescale 1ns/1ns

module sp_incrementor #(
    parameter int DATA_WIDTH = mem_addr_pkg::DATA_WIDTH
) (
    input  mem_addr_pkg::sp_step_t step,
    input  logic [DATA_WIDTH-1:0]  cur,
    input  logic [DATA_WIDTH-1:0]  first,    // Top slot of the active stack
    output logic [DATA_WIDTH-1:0]  next
);

    localparam logic [DATA_WIDTH-1:0] ONE = DATA_WIDTH'(1);

    always_comb begin
        case (step)
            mem_addr_pkg::SP_INC: begin
                next = cur + ONE;                // Pop moves toward the top
            end
            mem_addr_pkg::SP_DEC: begin
                next = cur - ONE;                // Stack grows downward
            end
            mem_addr_pkg::SP_EMPTY: begin
                next = mem_addr_pkg::SP_EMPTY_MARK;
            end
            mem_addr_pkg::SP_FIRST: begin
                next = first;                    // First push on empty stack
            end
            default: begin
                next = cur;
            end
        endcase
    end

endmodule

// ==== filelist.f ====
+incdir+tb
design/mem_addr_pkg.sv
design/sp_incrementor.sv
design/memory_address_handler.sv
design/core_state_regs.sv
design/data_memory.sv
design/mem_addr_top.sv
tb/mem_addr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing -f filelist.f --top-module mem_addr_tb \
        --Mdir obj_dir -o mem_addr_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_addr_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log_file"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation did not pass, see $log_file"
exit 1

// ==== tb/mem_addr_checks.svh ====
`ifndef MEM_ADDR_CHECKS_SVH
`define MEM_ADDR_CHECKS_SVH

int value_errors   = 0;
int timeout_errors = 0;

task automatic check_addr(
    input string                                what,
    input logic [mem_addr_pkg::ADDR_WIDTH-1:0] got,
    input logic [mem_addr_pkg::ADDR_WIDTH-1:0] exp
);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_data(
    input string                                what,
    input logic [mem_addr_pkg::DATA_WIDTH-1:0] got,
    input logic [mem_addr_pkg::DATA_WIDTH-1:0] exp
);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

// ==== tb/mem_addr_tb.sv ====
`timescale 1ns/1ns

module mem_addr_tb;

    localparam int AW = mem_addr_pkg::ADDR_WIDTH;
    localparam int DW = mem_addr_pkg::DATA_WIDTH;
    localparam logic [DW-1:0] EMPTY = mem_addr_pkg::SP_EMPTY_MARK;

    typedef struct packed {
        mem_addr_pkg::mem_cmd_t cmd;
        logic [AW-1:0]          exp_pc;      // After the command edge
        logic [DW-1:0]          exp_sp;      // Pointer of the command's mode
        logic                   exp_fault;
        logic                   rd_due;
        logic [DW-1:0]          exp_rd;
    } table_entry_t;

    logic                   clk;
    logic                   rst;
    mem_addr_pkg::mem_cmd_t cmd;
    logic [AW-1:0]          instr_addr;
    logic [AW-1:0]          pc;
    logic [DW-1:0]          sp;
    logic                   rd_valid;
    logic [DW-1:0]          rd_data;
    logic                   stack_fault;

    table_entry_t  stim[$];
    logic [AW-1:0] pc_count;
    int            seed = 27079;

    `include "mem_addr_checks.svh"

    mem_addr_top DUT (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .instr_addr (instr_addr),
        .pc         (pc),
        .sp         (sp),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .stack_fault(stack_fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Keeps the mode bit so sp shows the same stack
    function automatic mem_addr_pkg::mem_cmd_t idle_cmd(input logic kernel);
        mem_addr_pkg::mem_cmd_t c;
        c        = '0;
        c.kernel = kernel;
        return c;
    endfunction

    task automatic add_entry(
        input mem_addr_pkg::stack_op_t op,
        input logic                    kernel,
        input logic                    write,
        input logic [AW-1:0]           addr,
        input logic [DW-1:0]           wdata,
        input logic [DW-1:0]           exp_sp,
        input logic                    exp_fault,
        input logic                    rd_due,
        input logic [DW-1:0]           exp_rd
    );
        table_entry_t e;
        pc_count       = pc_count + AW'(1);      // Every entry is a valid command
        e.cmd.valid    = 1'b1;
        e.cmd.op       = op;
        e.cmd.kernel   = kernel;
        e.cmd.write    = write;
        e.cmd.addr     = addr;
        e.cmd.wdata    = wdata;
        e.exp_pc       = pc_count;
        e.exp_sp       = exp_sp;
        e.exp_fault    = exp_fault;
        e.rd_due       = rd_due;
        e.exp_rd       = exp_rd;
        stim.push_back(e);
    endtask

    task automatic build_table();
        logic [DW-1:0] d [5];
        logic [DW-1:0] fill_word;
        logic [DW-1:0] acc_word;
        pc_count = '0;
        for (int i = 0; i < 5; i++) begin
            d[i] = $random(seed);
        end
        // User stack, LIFO order
        add_entry(mem_addr_pkg::OP_PUSH, 1'b0, 1'b0, '0, d[0], 32'd8191, 1'b0, 1'b0, '0);
        add_entry(mem_addr_pkg::OP_PUSH, 1'b0, 1'b0, '0, d[1], 32'd8190, 1'b0, 1'b0, '0);
        add_entry(mem_addr_pkg::OP_PUSH, 1'b0, 1'b0, '0, d[2], 32'd8189, 1'b0, 1'b0, '0);
        add_entry(mem_addr_pkg::OP_POP, 1'b0, 1'b0, '0, '0, 32'd8190, 1'b0, 1'b1, d[2]);
        add_entry(mem_addr_pkg::OP_POP, 1'b0, 1'b0, '0, '0, 32'd8191, 1'b0, 1'b1, d[1]);
        add_entry(mem_addr_pkg::OP_POP, 1'b0, 1'b0, '0, '0, EMPTY, 1'b0, 1'b1, d[0]);
        // Mode separation
        add_entry(mem_addr_pkg::OP_PUSH, 1'b0, 1'b0, '0, d[3], 32'd8191, 1'b0, 1'b0, '0);
        add_entry(mem_addr_pkg::OP_PUSH, 1'b1, 1'b0, '0, d[4], 32'd6143, 1'b0, 1'b0, '0);
        add_entry(mem_addr_pkg::OP_ACCESS, 1'b0, 1'b0, 16'd8191, '0, 32'd8191,
                  1'b0, 1'b1, d[3]);
        add_entry(mem_addr_pkg::OP_POP, 1'b1, 1'b0, '0, '0, EMPTY, 1'b0, 1'b1, d[4]);
        // Underflow on the empty kernel stack
        add_entry(mem_addr_pkg::OP_POP, 1'b1, 1'b0, '0, '0, EMPTY, 1'b1, 1'b0, '0);
        add_entry(mem_addr_pkg::OP_POP, 1'b0, 1'b0, '0, '0, EMPTY, 1'b0, 1'b1, d[3]);
        // Fill the kernel stack down to its low bound
        fill_word = '0;
        for (int i = 0; i < 2048; i++) begin
            fill_word = $random(seed);
            add_entry(mem_addr_pkg::OP_PUSH, 1'b1, 1'b0, '0, fill_word,
                      32'(6143 - i), 1'b0, 1'b0, '0);
        end
        add_entry(mem_addr_pkg::OP_PUSH, 1'b1, 1'b0, '0, ~fill_word, 32'd4096,
                  1'b1, 1'b0, '0);                // Overflow, nothing written
        add_entry(mem_addr_pkg::OP_POP, 1'b1, 1'b0, '0, '0, 32'd4097, 1'b0, 1'b1, fill_word);
        // Plain store and load
        acc_word = $random(seed);
        add_entry(mem_addr_pkg::OP_ACCESS, 1'b0, 1'b1, 16'd100, acc_word, EMPTY,
                  1'b0, 1'b0, '0);
        add_entry(mem_addr_pkg::OP_ACCESS, 1'b0, 1'b0, 16'd100, '0, EMPTY,
                  1'b0, 1'b1, acc_word);
    endtask

    // Command cycle, then one idle cycle for the state and read checks
    task automatic apply_entry(input int idx, input table_entry_t e);
        int waited;
        cmd = e.cmd;
        @(negedge clk);
        check_flag("stack_fault", stack_fault, e.exp_fault);
        @(posedge clk);
        #1;
        cmd = idle_cmd(e.cmd.kernel);
        @(negedge clk);
        check_addr("pc", pc, e.exp_pc);
        check_addr("instr_addr", instr_addr, e.exp_pc);
        check_data("sp", sp, e.exp_sp);
        if (e.rd_due) begin
            waited = 0;
            while (!rd_valid && waited < 20) begin
                @(negedge clk);
                waited++;
            end
            if (rd_valid) begin
                check_flag("rd_valid one cycle after the read", waited == 0, 1'b1);
                check_data("rd_data", rd_data, e.exp_rd);
            end else begin
                timeout_errors++;
                $display("Timeout at %0t ns: the read of entry %0d never raised rd_valid",
                         $time, idx);
            end
        end else begin
            check_flag("rd_valid", rd_valid, 1'b0);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst       = 1'b1;
        cmd       = idle_cmd(1'b0);
        cmd.valid = 1'b1;                        // Read at word 0 that reset must override
        build_table();
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_addr("pc in reset", pc, '0);
        check_flag("rd_valid in reset", rd_valid, 1'b0);
        @(posedge clk);                          // Sixteenth reset cycle
        #1;
        rst = 1'b0;
        cmd = idle_cmd(1'b0);
        @(negedge clk);
        check_addr("pc after reset", pc, '0);
        check_data("user sp after reset", sp, EMPTY);
        check_flag("rd_valid after reset", rd_valid, 1'b0);
        @(posedge clk);
        #1;
        for (int i = 0; i < stim.size(); i++) begin
            apply_entry(i, stim[i]);
        end
        // Reset again while pc is nonzero, the last read held on the inputs
        rst = 1'b1;
        cmd = stim[stim.size()-1].cmd;
        @(negedge clk);
        check_addr("instr_addr in reset", instr_addr, '0);
        check_addr("pc before the reset edge", pc, pc_count);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        cmd = idle_cmd(1'b1);
        @(negedge clk);
        check_addr("pc after second reset", pc, '0);
        check_data("kernel sp after second reset", sp, EMPTY);
        check_flag("rd_valid after second reset", rd_valid, 1'b0);
        $display("Value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
